/* logic/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

    // First fetch address after reset
    localparam logic [31:0] RESET_PC = 32'h1c00_0000;

    // Instruction ROM, indexed by PC bits 6 down to 2
    localparam int unsigned ROM_WORDS      = 32;
    localparam int unsigned ROM_INDEX_BITS = $clog2(ROM_WORDS);

    // Program image shared by the ROM model and the testbench
    localparam string PROGRAM_FILE = "verif/program.hex";

    // Instruction queue toward decode, depth is a power of two
    localparam int unsigned QUEUE_DEPTH    = 4;
    localparam int unsigned QUEUE_PTR_BITS = $clog2(QUEUE_DEPTH);
    localparam int unsigned QUEUE_CNT_BITS = QUEUE_PTR_BITS + 1;

    // Redirect request from branch, exception entry or exception return
    typedef struct packed {
        logic        valid;
        logic [31:0] target;
    } redirect_t;

    // One fetched instruction as seen by decode
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        // Fetch address fault
        logic        adef;
    } fetch_bundle_t;

endpackage

`default_nettype wire

/* logic/pc_select.sv */
`default_nettype none

module pc_select (
    input  logic                 clk,
    input  logic                 reset,
    input  fetch_pkg::redirect_t br_redirect,
    input  fetch_pkg::redirect_t ex_redirect,
    input  fetch_pkg::redirect_t ertn_redirect,
    output logic                 rom_req,
    output logic [31:0]          rom_addr,
    input  logic                 rom_addr_ok,
    output logic                 issue_valid,
    output logic [31:0]          issue_pc,
    output logic                 issue_adef,
    input  logic                 allow_in
);
    import fetch_pkg::*;

    // Last issued PC
    logic [31:0] pc;
    logic        armed;
    logic        halted;
    logic        pend_valid;
    logic [31:0] pend_target;

    logic        live_valid;
    logic [31:0] live_target;
    logic        redir_valid;
    logic [31:0] redir_target;
    logic [31:0] next_pc;
    logic        misaligned;
    logic        active;

    // Redirect priority is ertn, then ex, then br
    always_comb begin
        if (ertn_redirect.valid) begin
            live_target = ertn_redirect.target;
        end else if (ex_redirect.valid) begin
            live_target = ex_redirect.target;
        end else begin
            live_target = br_redirect.target;
        end
    end

    assign live_valid = ertn_redirect.valid | ex_redirect.valid | br_redirect.valid;

    // A new redirect overrides an older pending one
    assign redir_valid  = live_valid | pend_valid;
    assign redir_target = live_valid ? live_target : pend_target;

    assign next_pc    = redir_valid ? redir_target : pc + 32'd4;
    assign misaligned = next_pc[1:0] != 2'b00;

    // After an address fault only a redirect restarts fetch
    assign active = armed & (~halted | redir_valid);

    // Faulting addresses never reach the ROM
    assign rom_req  = active & allow_in & ~misaligned;
    assign rom_addr = next_pc;

    assign issue_valid = active & allow_in & (misaligned | rom_addr_ok);
    assign issue_pc    = next_pc;
    assign issue_adef  = misaligned;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc     <= RESET_PC - 32'd4;
            armed  <= 1'b0;
            halted <= 1'b0;
        end else begin
            // First request goes out one cycle after reset
            armed <= 1'b1;
            if (issue_valid) begin
                pc <= next_pc;
            end
            if (issue_valid & misaligned) begin
                halted <= 1'b1;
            end else if (live_valid) begin
                halted <= 1'b0;
            end
        end
    end

    // Hold a redirect that could not be issued in its own cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            pend_valid <= 1'b0;
        end else if (issue_valid) begin
            pend_valid <= 1'b0;
        end else if (live_valid) begin
            pend_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (live_valid & ~issue_valid) begin
            pend_target <= live_target;
        end
    end

endmodule

`default_nettype wire

/* logic/fetch_stage.sv */
`default_nettype none

module fetch_stage (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     flush,
    input  logic                     issue_valid,
    input  logic [31:0]              issue_pc,
    input  logic                     issue_adef,
    output logic                     allow_in,
    input  logic                     rom_data_ok,
    input  logic [31:0]              rom_rdata,
    output logic                     enq_valid,
    output fetch_pkg::fetch_bundle_t enq_bundle,
    input  logic                     enq_ready
);

    logic        ent_valid;
    logic [31:0] ent_pc;
    logic        ent_adef;
    // Response belongs to a path abandoned by a redirect
    logic        ent_stale;
    logic        ent_has_data;
    logic [31:0] ent_inst;

    logic resp_now;
    logic ent_done;
    logic drop;
    logic leave;

    // Response arriving for an entry still waiting on the ROM
    assign resp_now = ent_valid & ~ent_adef & ~ent_has_data & rom_data_ok;

    // Entry has everything it needs for a bundle
    assign ent_done = ent_adef | ent_has_data | resp_now;

    // Stale or flushed entries are discarded once complete
    assign drop = ent_valid & ent_done & (ent_stale | flush);

    assign enq_valid = ent_valid & ent_done & ~ent_stale & ~flush;
    assign leave     = drop | (enq_valid & enq_ready);
    assign allow_in  = ~ent_valid | leave;

    assign enq_bundle.pc   = ent_pc;
    assign enq_bundle.adef = ent_adef;

    always_comb begin
        if (ent_adef) begin
            enq_bundle.inst = 32'd0;
        end else if (ent_has_data) begin
            enq_bundle.inst = ent_inst;
        end else begin
            enq_bundle.inst = rom_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ent_valid    <= 1'b0;
            ent_adef     <= 1'b0;
            ent_stale    <= 1'b0;
            ent_has_data <= 1'b0;
        end else if (issue_valid & allow_in) begin
            ent_valid    <= 1'b1;
            ent_adef     <= issue_adef;
            ent_stale    <= 1'b0;
            ent_has_data <= 1'b0;
        end else if (leave) begin
            ent_valid    <= 1'b0;
            ent_stale    <= 1'b0;
            ent_has_data <= 1'b0;
        end else begin
            // Redirect while the request is still in flight
            if (flush & ent_valid) begin
                ent_stale <= 1'b1;
            end
            // Queue full, keep the response here
            if (resp_now) begin
                ent_has_data <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid & allow_in) begin
            ent_pc <= issue_pc;
        end
        if (resp_now) begin
            ent_inst <= rom_rdata;
        end
    end

endmodule

`default_nettype wire

/* logic/inst_rom.sv */
`default_nettype none

module inst_rom (
    input  logic        clk,
    input  logic        reset,
    input  logic        req,
    input  logic [31:0] addr,
    output logic        addr_ok,
    output logic        data_ok,
    output logic [31:0] rdata,
    input  logic        resp_taken
);
    import fetch_pkg::*;

    logic [31:0] mem [ROM_WORDS];
    logic        accept;

    initial begin
        $readmemh(PROGRAM_FILE, mem);
    end

    // Stall new requests only while an untaken response is waiting
    assign addr_ok = ~data_ok | resp_taken;
    assign accept  = req & addr_ok;

    always_ff @(posedge clk) begin
        if (reset) begin
            data_ok <= 1'b0;
        end else if (accept) begin
            data_ok <= 1'b1;
        end else if (resp_taken) begin
            data_ok <= 1'b0;
        end
    end

    // Word index wraps over the ROM
    always_ff @(posedge clk) begin
        if (accept) begin
            rdata <= mem[addr[ROM_INDEX_BITS+1:2]];
        end
    end

endmodule

`default_nettype wire

/* logic/inst_queue.sv */
`default_nettype none

module inst_queue (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     flush,
    input  logic                     enq_valid,
    input  fetch_pkg::fetch_bundle_t enq_bundle,
    output logic                     enq_ready,
    output logic                     out_valid,
    output fetch_pkg::fetch_bundle_t out_bundle,
    input  logic                     out_ready
);
    import fetch_pkg::*;

    fetch_bundle_t             mem [QUEUE_DEPTH];
    logic [QUEUE_PTR_BITS-1:0] wr_ptr;
    logic [QUEUE_PTR_BITS-1:0] rd_ptr;
    logic [QUEUE_CNT_BITS-1:0] count;

    logic push;
    logic pop;

    assign enq_ready  = count != QUEUE_CNT_BITS'(QUEUE_DEPTH);
    assign out_valid  = count != '0;
    assign out_bundle = mem[rd_ptr];

    assign push = enq_valid & enq_ready;
    assign pop  = out_valid & out_ready;

    // Pointers wrap naturally at the power-of-two depth
    always_ff @(posedge clk) begin
        if (reset | flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push & ~pop) begin
                count <= count + 1'b1;
            end else if (pop & ~push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= enq_bundle;
        end
    end

endmodule

`default_nettype wire

/* logic/fetch_top.sv */
`default_nettype none

module fetch_top (
    input  logic                     clk,
    input  logic                     reset,
    input  fetch_pkg::redirect_t     br_redirect,
    input  fetch_pkg::redirect_t     ex_redirect,
    input  fetch_pkg::redirect_t     ertn_redirect,
    output logic                     out_valid,
    output fetch_pkg::fetch_bundle_t out_bundle,
    input  logic                     out_ready
);
    import fetch_pkg::*;

    logic          flush;
    logic          rom_req;
    logic [31:0]   rom_addr;
    logic          rom_addr_ok;
    logic          rom_data_ok;
    logic [31:0]   rom_rdata;
    logic          issue_valid;
    logic [31:0]   issue_pc;
    logic          issue_adef;
    logic          allow_in;
    logic          enq_valid;
    fetch_bundle_t enq_bundle;
    logic          enq_ready;

    // Any redirect kills the younger path
    assign flush = br_redirect.valid | ex_redirect.valid | ertn_redirect.valid;

    pc_select u_pc_select (
        .clk           (clk),
        .reset         (reset),
        .br_redirect   (br_redirect),
        .ex_redirect   (ex_redirect),
        .ertn_redirect (ertn_redirect),
        .rom_req       (rom_req),
        .rom_addr      (rom_addr),
        .rom_addr_ok   (rom_addr_ok),
        .issue_valid   (issue_valid),
        .issue_pc      (issue_pc),
        .issue_adef    (issue_adef),
        .allow_in      (allow_in)
    );

    // Fetch stage frees its entry exactly when the response is consumed
    inst_rom u_inst_rom (
        .clk        (clk),
        .reset      (reset),
        .req        (rom_req),
        .addr       (rom_addr),
        .addr_ok    (rom_addr_ok),
        .data_ok    (rom_data_ok),
        .rdata      (rom_rdata),
        .resp_taken (allow_in)
    );

    fetch_stage u_fetch_stage (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .issue_valid (issue_valid),
        .issue_pc    (issue_pc),
        .issue_adef  (issue_adef),
        .allow_in    (allow_in),
        .rom_data_ok (rom_data_ok),
        .rom_rdata   (rom_rdata),
        .enq_valid   (enq_valid),
        .enq_bundle  (enq_bundle),
        .enq_ready   (enq_ready)
    );

    inst_queue u_inst_queue (
        .clk        (clk),
        .reset      (reset),
        .flush      (flush),
        .enq_valid  (enq_valid),
        .enq_bundle (enq_bundle),
        .enq_ready  (enq_ready),
        .out_valid  (out_valid),
        .out_bundle (out_bundle),
        .out_ready  (out_ready)
    );

endmodule

`default_nettype wire

/* verif/fetch_tb.sv */
`default_nettype none

module fetch_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import fetch_pkg::*;

    // Directed traffic is a few hundred cycles, so this leaves a wide margin
    localparam int MAX_CYCLES = 4000;

    logic          clk;
    logic          reset;
    redirect_t     br_redirect;
    redirect_t     ex_redirect;
    redirect_t     ertn_redirect;
    logic          out_valid;
    fetch_bundle_t out_bundle;
    logic          out_ready;

    // Reference copy of the program
    logic [31:0] prog [ROM_WORDS];
    logic [31:0] lfsr_state;
    logic        random_ready;
    // Next pc expected from the decode side
    logic [31:0] exp_pc;
    int          cycle_count;
    int          check_count;
    int          error_count;
    int          test_count;

    fetch_top dut (
        .clk           (clk),
        .reset         (reset),
        .br_redirect   (br_redirect),
        .ex_redirect   (ex_redirect),
        .ertn_redirect (ertn_redirect),
        .out_valid     (out_valid),
        .out_bundle    (out_bundle),
        .out_ready     (out_ready)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, the DUT stopped delivering bundles", cycle_count);
            $display("Verification failed");
            $finish;
        end
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    function automatic redirect_t make_redirect(input logic [31:0] target);
        redirect_t r;
        r.valid  = 1'b1;
        r.target = target;
        return r;
    endfunction

    // Aligned fetch returns the program word at pc bits 6 down to 2
    function automatic fetch_bundle_t expected_bundle(input logic [31:0] pc);
        fetch_bundle_t b;
        b.pc   = pc;
        b.inst = prog[pc[6:2]];
        b.adef = 1'b0;
        return b;
    endfunction

    // One clock cycle; reports the bundle that transferred in it, if any
    task automatic step(output logic got, output fetch_bundle_t bundle);
        @(negedge clk);
        got    = out_valid & out_ready;
        bundle = out_bundle;
        @(posedge clk);
        #1;
        if (random_ready) begin
            lfsr_state = lfsr_next(lfsr_state);
            out_ready  = lfsr_state[0];
        end else begin
            out_ready = 1'b1;
        end
    endtask

    task automatic wait_bundle(output fetch_bundle_t bundle);
        logic got;
        got = 1'b0;
        while (!got) begin
            step(got, bundle);
        end
    endtask

    task automatic apply_redirect(input redirect_t br, input redirect_t ex,
                                  input redirect_t ertn);
        logic          got;
        fetch_bundle_t old;
        br_redirect   = br;
        ex_redirect   = ex;
        ertn_redirect = ertn;
        // Bundles leaving in the redirect cycle belong to the old path
        step(got, old);
        br_redirect   = '0;
        ex_redirect   = '0;
        ertn_redirect = '0;
    endtask

    task automatic check_bundle(input string test, input fetch_bundle_t expected,
                                input fetch_bundle_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("[ERROR] %s: expected pc=%h inst=%h adef=%b, actual pc=%h inst=%h adef=%b",
                     test, expected.pc, expected.inst, expected.adef,
                     actual.pc, actual.inst, actual.adef);
        end
    endtask

    task automatic collect_sequential(input string test, input int count);
        fetch_bundle_t b;
        for (int i = 0; i < count; i++) begin
            wait_bundle(b);
            check_bundle(test, expected_bundle(exp_pc), b);
            exp_pc = exp_pc + 32'd4;
        end
    endtask

    task automatic report(input string test, input int errors_before);
        test_count++;
        if (error_count == errors_before) begin
            $display("%s: ok", test);
        end else begin
            $display("%s: %0d errors", test, error_count - errors_before);
        end
    endtask

    task automatic test_sequential();
        int errors_before;
        errors_before = error_count;
        random_ready  = 1'b0;
        exp_pc        = RESET_PC;
        // 40 words run past the end of the 32-word ROM
        collect_sequential("sequential_fetch", 40);
        report("sequential_fetch", errors_before);
    endtask

    task automatic test_backpressure();
        int errors_before;
        errors_before = error_count;
        random_ready  = 1'b1;
        collect_sequential("back_pressure", 60);
        random_ready = 1'b0;
        report("back_pressure", errors_before);
    endtask

    task automatic test_branch();
        int          errors_before;
        logic [31:0] target;
        errors_before = error_count;
        target        = 32'h1c00_0248;
        // Random ready so the redirect can land while a request is in flight
        random_ready  = 1'b1;
        apply_redirect(make_redirect(target), '0, '0);
        exp_pc = target;
        collect_sequential("branch_redirect", 16);
        random_ready = 1'b0;
        report("branch_redirect", errors_before);
    endtask

    task automatic test_priority();
        int          errors_before;
        logic [31:0] br_target;
        logic [31:0] ex_target;
        logic [31:0] ertn_target;
        errors_before = error_count;
        br_target     = 32'h1c00_0060;
        ex_target     = 32'h1c00_0040;
        ertn_target   = 32'h1c00_0020;
        random_ready  = 1'b0;
        apply_redirect(make_redirect(br_target), make_redirect(ex_target),
                       make_redirect(ertn_target));
        exp_pc = ertn_target;
        collect_sequential("priority", 4);
        // Without ertn the exception target wins
        apply_redirect(make_redirect(br_target), make_redirect(ex_target), '0);
        exp_pc = ex_target;
        collect_sequential("priority", 4);
        report("priority", errors_before);
    endtask

    task automatic test_address_fault();
        int            errors_before;
        logic [31:0]   bad_target;
        logic [31:0]   good_target;
        fetch_bundle_t fault;
        fetch_bundle_t b;
        logic          got;
        errors_before = error_count;
        bad_target    = 32'h1c00_0036;
        good_target   = 32'h1c00_0010;
        random_ready  = 1'b0;
        apply_redirect(make_redirect(bad_target), '0, '0);
        fault.pc   = bad_target;
        fault.inst = 32'd0;
        fault.adef = 1'b1;
        wait_bundle(b);
        check_bundle("address_fault", fault, b);
        // Fetch stays halted until the next redirect
        check_count++;
        repeat (20) begin
            step(got, b);
            if (got) begin
                error_count++;
                $display("[ERROR] address_fault: bundle with pc %h arrived while fetch was halted",
                         b.pc);
            end
        end
        apply_redirect(make_redirect(good_target), '0, '0);
        exp_pc = good_target;
        collect_sequential("address_fault", 8);
        report("address_fault", errors_before);
    endtask

    initial begin
        clk           = 1'b0;
        reset         = 1'b1;
        br_redirect   = '0;
        ex_redirect   = '0;
        ertn_redirect = '0;
        out_ready     = 1'b1;
        random_ready  = 1'b0;
        lfsr_state    = 32'ha447_6fec;
        exp_pc        = RESET_PC;
        cycle_count   = 0;
        check_count   = 0;
        error_count   = 0;
        test_count    = 0;
        $readmemh(PROGRAM_FILE, prog);
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;

        test_sequential();
        test_backpressure();
        test_branch();
        test_priority();
        test_address_fault();

        $display("Tests: %0d, checks: %0d, errors: %0d", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* fetch.f */
logic/fetch_pkg.sv
logic/pc_select.sv
logic/fetch_stage.sv
logic/inst_rom.sv
logic/inst_queue.sv
logic/fetch_top.sv
verif/fetch_tb.sv

/* Makefile */
# Verilator build and run of the fetch front end testbench

VERILATOR ?= verilator
TOP       ?= fetch_tb
FILELIST  ?= fetch.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf $(OBJ_DIR)

/* verif/program.hex */
// One 32-bit instruction word per line, word index 0 to 31
02800404
02800805
00101886
02bffcc6
5c000ce4
28c00087
29c000a8
0015008a
0280100b
0010356c
00109d8d
0011312e
1400002f
03400000
4c000020
02808410
00150211
1c000012
02bff252
58000e51
28800213
29800214
00114e95
0040a2b6
0044c2d7
00141718
002a0000
06483800
50002000
54003400
0284c319
00df1f3a
